/* design/corePkg.sv */
package corePkg;

  typedef logic [31:0] word;
  typedef logic [4:0] regIndex;

  typedef enum logic [3:0] {
    aluAdd   = 4'd0,
    aluSub   = 4'd1,
    aluAnd   = 4'd2,
    aluOr    = 4'd3,
    aluXor   = 4'd4,
    aluSlt   = 4'd5,
    aluSltu  = 4'd6,
    aluSll   = 4'd7,
    aluSrl   = 4'd8,
    aluSra   = 4'd9,
    aluPassB = 4'd10
  } aluOp;

  // RV32I major opcodes in bits [6:0].
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opBranch = 7'b1100011;

  localparam word nop = 32'h0000_0013; // addi x0, x0, 0.

endpackage

/* design/decodeStage.sv */
module decodeStage (
  input  logic              clk,
  input  logic              rst,
  input  corePkg::word      instr,
  input  corePkg::word      instrPc,
  input  logic              instrValid,
  input  logic              wbValid,
  input  corePkg::regIndex  wbIndex,
  input  corePkg::word      wbData,
  output corePkg::word      idPc,
  output corePkg::word      idLhsValue,
  output corePkg::word      idRhsValue,
  output corePkg::regIndex  idLhsIndex,
  output corePkg::regIndex  idRhsIndex,
  output corePkg::regIndex  idWriteIndex,
  output corePkg::word      idImmediate,
  output corePkg::aluOp     idAluOp,
  output logic              idAluSrc,
  output logic              idPcToAlu,
  output logic              idRegWrite,
  output logic              idJump,
  output logic              idJumpRegister,
  output logic              idBranch,
  output logic [2:0]        idFunct3,
  output logic              idValid
);

  corePkg::word regs [32];
  corePkg::word ins;
  corePkg::word immI;
  corePkg::word immU;
  corePkg::word immB;
  corePkg::word immJ;
  corePkg::aluOp functOp;
  logic [6:0] opcode;
  logic [6:0] funct7;

  assign ins = instrValid ? instr : corePkg::nop; // bubble decodes as nop.

  assign opcode = ins[6:0];
  assign funct7 = ins[31:25];
  assign idFunct3 = ins[14:12];
  assign idWriteIndex = ins[11:7];
  assign idLhsIndex = ins[19:15];
  assign idRhsIndex = ins[24:20];
  assign idPc = instrPc;
  assign idValid = instrValid;

  assign immI = {{20{ins[31]}}, ins[31:20]};
  assign immU = {ins[31:12], 12'b0};
  assign immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  assign immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

  always_comb begin
    case (idFunct3)
      3'b000: functOp = (opcode == corePkg::opOp && funct7[5]) ? corePkg::aluSub
                                                                : corePkg::aluAdd;
      3'b001: functOp = corePkg::aluSll;
      3'b010: functOp = corePkg::aluSlt;
      3'b011: functOp = corePkg::aluSltu;
      3'b100: functOp = corePkg::aluXor;
      3'b101: functOp = funct7[5] ? corePkg::aluSra : corePkg::aluSrl;
      3'b110: functOp = corePkg::aluOr;
      default: functOp = corePkg::aluAnd;
    endcase
  end

  always_comb begin
    idAluOp = corePkg::aluAdd;
    idAluSrc = 1'b0;
    idPcToAlu = 1'b0;
    idRegWrite = 1'b0;
    idJump = 1'b0;
    idJumpRegister = 1'b0;
    idBranch = 1'b0;
    idImmediate = immI;
    case (opcode)
      corePkg::opOp: begin
        idAluOp = functOp;
        idRegWrite = instrValid;
      end
      corePkg::opOpImm: begin
        idAluOp = functOp;
        idAluSrc = 1'b1;
        idRegWrite = instrValid; // nop lands here too.
      end
      corePkg::opLui: begin
        idAluOp = corePkg::aluPassB;
        idAluSrc = 1'b1;
        idImmediate = immU;
        idRegWrite = 1'b1;
      end
      corePkg::opAuipc: begin
        idAluSrc = 1'b1;
        idPcToAlu = 1'b1;
        idImmediate = immU;
        idRegWrite = 1'b1;
      end
      corePkg::opJal: begin
        idJump = 1'b1;
        idImmediate = immJ;
        idRegWrite = 1'b1;
      end
      corePkg::opJalr: begin
        idJump = 1'b1;
        idJumpRegister = 1'b1;
        idRegWrite = 1'b1;
      end
      corePkg::opBranch: begin
        idBranch = 1'b1;
        idImmediate = immB;
      end
      default: begin
        idImmediate = immI; // unsupported opcodes act as bubbles.
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wbValid && wbIndex != '0) begin
      regs[wbIndex] <= wbData;
    end
  end

  // same-cycle writeback wins over the stored value.
  always_comb begin
    if (idLhsIndex == '0) begin
      idLhsValue = '0;
    end else if (wbValid && wbIndex == idLhsIndex) begin
      idLhsValue = wbData;
    end else begin
      idLhsValue = regs[idLhsIndex];
    end
  end

  always_comb begin
    if (idRhsIndex == '0) begin
      idRhsValue = '0;
    end else if (wbValid && wbIndex == idRhsIndex) begin
      idRhsValue = wbData;
    end else begin
      idRhsValue = regs[idRhsIndex];
    end
  end

endmodule

/* design/idExBarrier.sv */
module idExBarrier (
  input  logic              clk,
  input  logic              rst,
  input  logic              hold,
  input  logic              flush,
  input  corePkg::word      idPc,
  input  corePkg::word      idLhsValue,
  input  corePkg::word      idRhsValue,
  input  corePkg::regIndex  idLhsIndex,
  input  corePkg::regIndex  idRhsIndex,
  input  corePkg::regIndex  idWriteIndex,
  input  corePkg::word      idImmediate,
  input  corePkg::aluOp     idAluOp,
  input  logic              idAluSrc,
  input  logic              idPcToAlu,
  input  logic              idRegWrite,
  input  logic              idJump,
  input  logic              idJumpRegister,
  input  logic              idBranch,
  input  logic [2:0]        idFunct3,
  input  logic              idValid,
  output corePkg::word      exPc,
  output corePkg::word      exLhsValue,
  output corePkg::word      exRhsValue,
  output corePkg::regIndex  exLhsIndex,
  output corePkg::regIndex  exRhsIndex,
  output corePkg::regIndex  exWriteIndex,
  output corePkg::word      exImmediate,
  output corePkg::aluOp     exAluOp,
  output logic              exAluSrc,
  output logic              exPcToAlu,
  output logic              exRegWrite,
  output logic              exJump,
  output logic              exJumpRegister,
  output logic              exBranch,
  output logic [2:0]        exFunct3,
  output logic              exValid
);

  always_ff @(posedge clk) begin
    if (!hold) begin
      exPc <= idPc;
      exLhsValue <= idLhsValue;
      exRhsValue <= idRhsValue;
      exLhsIndex <= idLhsIndex;
      exRhsIndex <= idRhsIndex;
      exWriteIndex <= idWriteIndex;
      exImmediate <= idImmediate;
      exAluSrc <= idAluSrc;
      exPcToAlu <= idPcToAlu;
      exFunct3 <= idFunct3;
    end
  end

  // a held jump keeps its slot until hold drops.
  always_ff @(posedge clk) begin
    if (rst || (flush && !hold)) begin
      exAluOp <= corePkg::aluAdd;
      exRegWrite <= 1'b0;
      exJump <= 1'b0;
      exJumpRegister <= 1'b0;
      exBranch <= 1'b0;
      exValid <= 1'b0;
    end else if (!hold) begin
      exAluOp <= idAluOp;
      exRegWrite <= idRegWrite;
      exJump <= idJump;
      exJumpRegister <= idJumpRegister;
      exBranch <= idBranch;
      exValid <= idValid;
    end
  end

endmodule

/* design/executeStage.sv */
module executeStage (
  input  logic              clk,
  input  logic              rst,
  input  corePkg::word      exPc,
  input  corePkg::word      exLhsValue,
  input  corePkg::word      exRhsValue,
  input  corePkg::regIndex  exLhsIndex,
  input  corePkg::regIndex  exRhsIndex,
  input  corePkg::regIndex  exWriteIndex,
  input  corePkg::word      exImmediate,
  input  corePkg::aluOp     exAluOp,
  input  logic              exAluSrc,
  input  logic              exPcToAlu,
  input  logic              exRegWrite,
  input  logic              exJump,
  input  logic              exJumpRegister,
  input  logic              exBranch,
  input  logic [2:0]        exFunct3,
  input  logic              exValid,
  output logic              redirect,
  output corePkg::word      redirectPc,
  output logic              wbValid,
  output corePkg::regIndex  wbIndex,
  output corePkg::word      wbData
);

  corePkg::word lhs;
  corePkg::word rhs;
  corePkg::word opA;
  corePkg::word opB;
  corePkg::word aluResult;
  corePkg::word result;
  corePkg::word lastPc;
  corePkg::word lastLhs;
  corePkg::word lastRhs;
  logic lastValid;
  logic isRepeat;
  logic taken;

  // a held instruction reuses the operands it resolved first time round.
  assign isRepeat = lastValid && exValid && lastPc == exPc;

  always_comb begin
    if (isRepeat) begin
      lhs = lastLhs;
    end else if (wbValid && wbIndex != '0 && wbIndex == exLhsIndex) begin
      lhs = wbData;
    end else begin
      lhs = exLhsValue;
    end
  end

  always_comb begin
    if (isRepeat) begin
      rhs = lastRhs;
    end else if (wbValid && wbIndex != '0 && wbIndex == exRhsIndex) begin
      rhs = wbData;
    end else begin
      rhs = exRhsValue;
    end
  end

  assign opA = exPcToAlu ? exPc : lhs;
  assign opB = exAluSrc ? exImmediate : rhs;

  always_comb begin
    case (exAluOp)
      corePkg::aluAdd: aluResult = opA + opB;
      corePkg::aluSub: aluResult = opA - opB;
      corePkg::aluAnd: aluResult = opA & opB;
      corePkg::aluOr: aluResult = opA | opB;
      corePkg::aluXor: aluResult = opA ^ opB;
      corePkg::aluSlt: aluResult = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
      corePkg::aluSltu: aluResult = (opA < opB) ? 32'd1 : 32'd0;
      corePkg::aluSll: aluResult = opA << opB[4:0];
      corePkg::aluSrl: aluResult = opA >> opB[4:0];
      corePkg::aluSra: aluResult = $signed(opA) >>> opB[4:0];
      corePkg::aluPassB: aluResult = opB;
      default: aluResult = '0;
    endcase
  end

  always_comb begin
    case (exFunct3)
      3'b000: taken = lhs == rhs;
      3'b001: taken = lhs != rhs;
      3'b100: taken = $signed(lhs) < $signed(rhs);
      3'b101: taken = $signed(lhs) >= $signed(rhs);
      3'b110: taken = lhs < rhs;
      3'b111: taken = lhs >= rhs;
      default: taken = 1'b0; // reserved encodings.
    endcase
  end

  assign redirect = exValid && (exJump || (exBranch && taken));
  assign redirectPc = exJumpRegister ? ((lhs + exImmediate) & ~32'd1) : exPc + exImmediate;
  assign result = exJump ? exPc + 32'd4 : aluResult; // link address.

  always_ff @(posedge clk) begin
    if (rst) begin
      wbValid <= 1'b0;
      lastValid <= 1'b0;
    end else begin
      wbValid <= exValid && exRegWrite;
      lastValid <= exValid;
    end
  end

  always_ff @(posedge clk) begin
    wbIndex <= exWriteIndex;
    wbData <= result;
    lastPc <= exPc;
    lastLhs <= lhs;
    lastRhs <= rhs;
  end

endmodule

/* design/coreSlice.sv */
module coreSlice (
  input  logic              clk,
  input  logic              rst,
  input  corePkg::word      instr,
  input  corePkg::word      instrPc,
  input  logic              instrValid,
  input  logic              hold,
  output logic              wbValid,
  output corePkg::regIndex  wbIndex,
  output corePkg::word      wbData,
  output logic              redirect,
  output corePkg::word      redirectPc
);

  corePkg::word idPc, idLhsValue, idRhsValue, idImmediate;
  corePkg::regIndex idLhsIndex, idRhsIndex, idWriteIndex;
  corePkg::aluOp idAluOp;
  logic idAluSrc, idPcToAlu, idRegWrite;
  logic idJump, idJumpRegister, idBranch, idValid;
  logic [2:0] idFunct3;

  corePkg::word exPc, exLhsValue, exRhsValue, exImmediate;
  corePkg::regIndex exLhsIndex, exRhsIndex, exWriteIndex;
  corePkg::aluOp exAluOp;
  logic exAluSrc, exPcToAlu, exRegWrite;
  logic exJump, exJumpRegister, exBranch, exValid;
  logic [2:0] exFunct3;

  decodeStage decode_i (.*);

  // a taken redirect squashes whatever decode holds.
  idExBarrier barrier_i (
    .flush(redirect),
    .*
  );

  executeStage execute_i (.*);

endmodule

/* verification/coreSlice_chk.sv */
module coreSlice_chk (
  input logic             clk,
  input logic             rst,
  input logic             hold,
  input logic             instrValid,
  input corePkg::word     instr,
  input corePkg::word     instrPc,
  input logic             wbValid,
  input corePkg::regIndex wbIndex,
  input corePkg::word     wbData,
  input logic             redirect,
  input corePkg::word     redirectPc
);

  corePkg::word shadow [32];
  corePkg::word exInstr;
  corePkg::word exPc;
  corePkg::word lhs;
  corePkg::word rhs;
  corePkg::word immI;
  corePkg::word expResult;
  corePkg::word expTarget;
  corePkg::word expWbData;
  corePkg::regIndex expWbIndex;
  logic [2:0] f3;
  logic exValid;
  logic expWrite;
  logic expRedirect;
  logic expWbValid;
  logic failed = 1'b0;

  function automatic corePkg::word isaAlu(input logic [2:0] op, input logic alt,
                                          input corePkg::word a, input corePkg::word b);
    case (op)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, $signed(a) < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic isaTaken(input logic [2:0] op, input corePkg::word a,
                                    input corePkg::word b);
    case (op)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  assign f3 = exInstr[14:12];
  assign lhs = shadow[exInstr[19:15]];
  assign rhs = shadow[exInstr[24:20]];
  assign immI = {{20{exInstr[31]}}, exInstr[31:20]};

  always_comb begin
    expWrite = exValid;
    expRedirect = 1'b0;
    expResult = exPc + 32'd4; // link address for jumps.
    expTarget = exPc + {{19{exInstr[31]}}, exInstr[31], exInstr[7], exInstr[30:25],
                        exInstr[11:8], 1'b0};
    case (exInstr[6:0])
      corePkg::opOp: expResult = isaAlu(f3, exInstr[30], lhs, rhs);
      corePkg::opOpImm: expResult = isaAlu(f3, exInstr[30] && f3 == 3'd5, lhs, immI);
      corePkg::opLui: expResult = {exInstr[31:12], 12'd0};
      corePkg::opAuipc: expResult = exPc + {exInstr[31:12], 12'd0};
      corePkg::opJal: begin
        expRedirect = exValid;
        expTarget = exPc + {{11{exInstr[31]}}, exInstr[31], exInstr[19:12], exInstr[20],
                            exInstr[30:21], 1'b0};
      end
      corePkg::opJalr: begin
        expRedirect = exValid;
        expTarget = (lhs + immI) & ~32'd1;
      end
      corePkg::opBranch: begin
        expWrite = 1'b0;
        expRedirect = exValid && isaTaken(f3, lhs, rhs);
      end
      default: expWrite = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      exValid <= 1'b0;
      expWbValid <= 1'b0;
      for (int i = 0; i < 32; i++) begin
        shadow[i] <= '0;
      end
    end else begin
      expWbValid <= expWrite;
      expWbIndex <= exInstr[11:7];
      expWbData <= expResult;
      if (!hold) begin // the instruction leaves execute.
        exInstr <= instr;
        exPc <= instrPc;
        exValid <= instrValid && !expRedirect;
        if (expWrite && exInstr[11:7] != 5'd0) begin
          shadow[exInstr[11:7]] <= expResult;
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) wbValid == expWbValid)
    else begin
      $error("** Error at %0t: wbValid %b, expected %b", $time, wbValid, expWbValid);
      failed = 1'b1;
    end

  assert property (@(posedge clk) disable iff (rst)
                   wbValid |-> wbIndex == expWbIndex && wbData == expWbData)
    else begin
      $error("** Error at %0t: writeback x%0d = %h, expected x%0d = %h", $time,
             wbIndex, wbData, expWbIndex, expWbData);
      failed = 1'b1;
    end

  assert property (@(posedge clk) disable iff (rst) redirect == expRedirect)
    else begin
      $error("** Error at %0t: redirect %b, expected %b", $time, redirect, expRedirect);
      failed = 1'b1;
    end

  assert property (@(posedge clk) disable iff (rst) redirect |-> redirectPc == expTarget)
    else begin
      $error("** Error at %0t: redirectPc %h, expected %h", $time, redirectPc, expTarget);
      failed = 1'b1;
    end

endmodule

bind coreSlice coreSlice_chk chk_i (
  .clk(clk),
  .rst(rst),
  .hold(hold),
  .instrValid(instrValid),
  .instr(instr),
  .instrPc(instrPc),
  .wbValid(wbValid),
  .wbIndex(wbIndex),
  .wbData(wbData),
  .redirect(redirect),
  .redirectPc(redirectPc)
);

/* verification/coreSliceTb.sv */
module coreSliceTb;

  localparam int randomCount = 300;
  localparam int cycleLimit = 100 + randomCount * 6; // stalls add up to four cycles.

  logic clk;
  logic rst;
  corePkg::word instr;
  corePkg::word instrPc;
  logic instrValid;
  logic hold;
  logic wbValid;
  corePkg::regIndex wbIndex;
  corePkg::word wbData;
  logic redirect;
  corePkg::word redirectPc;
  logic [31:0] lfsr = 32'h4cf0_7641;
  corePkg::word pc;
  corePkg::word redirectTarget;
  logic redirectSeen;

  coreSlice dut_i (.*);

  always #50 clk = ~clk;

  // target stays pending until the next instruction takes it.
  always @(negedge clk) begin
    if (redirect === 1'b1) begin
      redirectSeen = 1'b1;
      redirectTarget = redirectPc;
    end
    if (dut_i.chk_i.failed) begin
      $display(">>> FAIL");
      $fatal(1, "a checker assertion failed");
    end
  end

  initial begin
    #(cycleLimit * 100);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired before the test sequence finished");
  end

  function automatic logic [31:0] randomBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic corePkg::word rType(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, corePkg::opOp};
  endfunction

  function automatic corePkg::word iType(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic corePkg::word uType(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic corePkg::word bType(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], corePkg::opBranch};
  endfunction

  function automatic corePkg::word jType(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, corePkg::opJal};
  endfunction

  // small register range keeps dependencies frequent.
  function automatic corePkg::word randomInstr();
    logic [31:0] r;
    logic [2:0] f3;
    logic [11:0] imm;
    r = randomBits(29);
    f3 = r[5:3];
    imm = r[26:15];
    case (r[2:0])
      3'd0, 3'd1: return rType({1'b0, r[27] && (f3 == 3'd0 || f3 == 3'd5), 5'd0},
                               {2'd0, r[14:12]}, {2'd0, r[11:9]}, f3, {2'd0, r[8:6]});
      3'd2, 3'd3: begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          imm[11:5] = {1'b0, r[27] && f3 == 3'd5, 5'd0}; // legal shift encodings.
        end
        return iType(imm, {2'd0, r[11:9]}, f3, {2'd0, r[8:6]}, corePkg::opOpImm);
      end
      3'd4: return uType(r[28:9], {2'd0, r[8:6]}, r[27] ? corePkg::opLui : corePkg::opAuipc);
      3'd5: return jType({{13{r[20]}}, r[20:15], 2'd0}, {2'd0, r[8:6]});
      3'd6: return iType(imm, {2'd0, r[11:9]}, 3'd0, {2'd0, r[8:6]}, corePkg::opJalr);
      default: return bType({{5{r[20]}}, r[20:15], 2'd0}, {2'd0, r[14:12]},
                            {2'd0, r[11:9]}, (f3 == 3'd2 || f3 == 3'd3) ? 3'd0 : f3);
    endcase
  endfunction

  task automatic present(input corePkg::word ins);
    @(posedge clk);
    pc = redirectSeen ? redirectTarget : pc + 32'd4;
    redirectSeen = 1'b0;
    instr <= ins;
    instrPc <= pc;
    instrValid <= 1'b1;
    hold <= 1'b0;
  endtask

  task automatic stall(input int n);
    repeat (n) begin
      @(posedge clk);
      instrValid <= 1'b0;
      hold <= 1'b1;
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    instr = corePkg::nop;
    instrPc = '0;
    instrValid = 1'b0;
    hold = 1'b0;
    pc = 32'h0000_00fc;
    redirectSeen = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    present(iType(12'd5, 5'd0, 3'd0, 5'd1, corePkg::opOpImm));
    present(iType(12'd3, 5'd1, 3'd0, 5'd2, corePkg::opOpImm)); // back to back.
    present(rType(7'd0, 5'd2, 5'd1, 3'd0, 5'd3)); // x1 at distance two.
    present(rType(7'h20, 5'd1, 5'd3, 3'd0, 5'd4));
    present(uType(20'h12345, 5'd5, corePkg::opLui));
    present(uType(20'h00001, 5'd6, corePkg::opAuipc));
    present(iType(12'd9, 5'd0, 3'd0, 5'd0, corePkg::opOpImm));
    present(rType(7'd0, 5'd0, 5'd0, 3'd0, 5'd7));
    present(iType(12'd1, 5'd1, 3'd0, 5'd1, corePkg::opOpImm));
    stall(4);
    present(rType(7'd0, 5'd1, 5'd1, 3'd0, 5'd8));
    present(bType(13'd8, 5'd1, 5'd1, 3'd0)); // taken.
    present(iType(12'd1, 5'd0, 3'd0, 5'd9, corePkg::opOpImm));
    present(bType(13'd8, 5'd2, 5'd1, 3'd0)); // not taken.
    present(jType(21'd16, 5'd10));
    present(iType(12'd1, 5'd0, 3'd0, 5'd9, corePkg::opOpImm));
    present(iType(12'h200, 5'd0, 3'd0, 5'd12, corePkg::opOpImm));
    present(iType(12'd5, 5'd12, 3'd0, 5'd11, corePkg::opJalr));
    present(iType(12'd1, 5'd0, 3'd0, 5'd9, corePkg::opOpImm));
    present(jType(21'd8, 5'd13));
    stall(3);
    for (int i = 0; i < randomCount; i++) begin
      present(randomInstr());
      if (randomBits(3) == 32'd0) begin
        stall(int'(randomBits(2)) + 1);
      end
    end
    repeat (4) begin
      @(posedge clk);
      instrValid <= 1'b0;
      hold <= 1'b0;
    end
    @(negedge clk);
    if (dut_i.chk_i.failed) begin
      $display(">>> FAIL");
      $fatal(1, "a checker assertion failed");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

/* coreSlice.f */
design/corePkg.sv
design/decodeStage.sv
design/idExBarrier.sv
design/executeStage.sv
design/coreSlice.sv
verification/coreSlice_chk.sv
verification/coreSliceTb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module coreSliceTb -f coreSlice.f -o simv
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/simv +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1
